//--- vlog.f
hdl/bcm_reg_pkg.sv
hdl/bcm_clk_pkg.sv
hdl/bcm_sync_cell.sv
hdl/bcm_apb_regs.sv
hdl/bcm_clk_sources.sv
hdl/bcm_clk_divider.sv
hdl/bcm_top.sv
tb/bcm_divider_assert.sv
tb/tb_bcm.sv

//--- Makefile
# Verilator simulation of the basic clock module

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_bcm
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_bcm.sv
`timescale 1ns/1ps

module tb_bcm;

  import bcm_reg_pkg::*;

  localparam int CLK_PERIOD = 10;
  // Words holding the two control bytes
  localparam logic [15:0] BCSCTL1_WORD = 16'h0056;
  localparam logic [15:0] BCSCTL2_WORD = 16'h0058;
  // BCSCTL1 keeps only DIVAx
  localparam logic [7:0] BCSCTL1_KEEP = 8'h30;
  // BCSCTL2 keeps SELS and DIVSx
  localparam logic [7:0] BCSCTL2_KEEP = 8'h0E;
  // Crystal period in mclk cycles
  localparam int LFXT_CYCLES = 8;
  // Three sweeps over all divide codes plus register traffic and settling
  localparam int RUN_CYCLES = 3 * 64 * (1 + 2 + 4 + 8) + 1000;

  logic        mclk;
  logic        puc_rst;
  logic [15:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] pwdata;
  logic [1:0]  pstrb;
  logic [15:0] prdata;
  logic        lfxt_clk;
  logic        oscoff;
  logic        scg1;
  logic        cpu_en;
  logic        cpu_en_s;
  logic        aclk_en;
  logic        smclk_en;
  logic [2:0]  lfxt_cnt;
  int          errors;

  bcm_top uut (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .pstrb    (pstrb),
    .prdata   (prdata),
    .lfxt_clk (lfxt_clk),
    .oscoff   (oscoff),
    .scg1     (scg1),
    .cpu_en   (cpu_en),
    .cpu_en_s (cpu_en_s),
    .aclk_en  (aclk_en),
    .smclk_en (smclk_en)
  );

  always #(CLK_PERIOD / 2) mclk = ~mclk;

  // Crystal square wave with 4 cycles high and 4 low
  always @(posedge mclk) begin
    lfxt_cnt <= lfxt_cnt + 3'd1;
    lfxt_clk <= lfxt_cnt[2];
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("** Error at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge mclk);
  endtask

  // Setup phase then access phase
  // Write lands at the edge that closes the access phase
  task automatic apb_write(input logic [15:0] addr, input logic [15:0] data,
                           input logic [1:0] strb);
    @(posedge mclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    pstrb   <= strb;
    @(posedge mclk);
    penable <= 1'b1;
    @(posedge mclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // Read data sampled mid access phase
  task automatic apb_read(input logic [15:0] addr, output int data);
    @(posedge mclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge mclk);
    penable <= 1'b1;
    @(negedge mclk);
    data = int'(prdata);
    @(posedge mclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_divax(input int code);
    apb_write(BCSCTL1_WORD, 16'(code << (8 + DIVAX_LSB)), 2'b10);
  endtask

  task automatic write_bcsctl2(input int sel, input int code);
    apb_write(BCSCTL2_WORD, 16'((sel << SELS_BIT) | (code << DIVSX_LSB)), 2'b01);
  endtask

  // Enables sampled on the falling edge between DUT updates
  task automatic count_enables(input int cycles, output int n_aclk, output int n_smclk);
    n_aclk  = 0;
    n_smclk = 0;
    repeat (cycles) begin
      @(negedge mclk);
      n_aclk  += int'(aclk_en);
      n_smclk += int'(smclk_en);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset();
    int rd;
    repeat (5) begin
      @(negedge mclk);
      check(int'(aclk_en), 0, "aclk_en during reset");
      check(int'(smclk_en), 0, "smclk_en during reset");
    end
    @(posedge mclk);
    puc_rst <= 1'b0;
    // cpu_en_s still crossing its synchronizer
    repeat (2) begin
      @(negedge mclk);
      check(int'(aclk_en), 0, "aclk_en after reset");
      check(int'(smclk_en), 0, "smclk_en after reset");
    end
    apb_read(BCSCTL1_WORD, rd);
    check(rd, 0, "BCSCTL1 after reset");
    apb_read(BCSCTL2_WORD, rd);
    check(rd, 0, "BCSCTL2 after reset");
  endtask

  task automatic test_registers();
    logic [31:0] rnd;
    logic [7:0]  v1;
    logic [7:0]  v2;
    int          rd;
    for (int i = 0; i < 8; i++) begin
      rnd = $urandom;
      v1  = rnd[7:0];
      v2  = rnd[15:8];
      // Noise in the other lane hits no register
      apb_write(BCSCTL1_WORD, {v1, rnd[23:16]}, 2'b11);
      apb_write(BCSCTL2_WORD, {rnd[31:24], v2}, 2'b11);
      apb_read(BCSCTL1_WORD, rd);
      check(rd, int'({v1 & BCSCTL1_KEEP, 8'h00}), "BCSCTL1 readback");
      apb_read(BCSCTL2_WORD, rd);
      check(rd, int'({8'h00, v2 & BCSCTL2_KEEP}), "BCSCTL2 readback");
    end
    // Inverted data with the register lane strobe off
    apb_write(BCSCTL1_WORD, {~v1, 8'hFF}, 2'b01);
    apb_write(BCSCTL2_WORD, {8'hFF, ~v2}, 2'b10);
    apb_read(BCSCTL1_WORD, rd);
    check(rd, int'({v1 & BCSCTL1_KEEP, 8'h00}), "BCSCTL1 with strobe cleared");
    apb_read(BCSCTL2_WORD, rd);
    check(rd, int'({8'h00, v2 & BCSCTL2_KEEP}), "BCSCTL2 with strobe cleared");
    // Both registers nonzero so a decode leak shows up
    apb_write(BCSCTL1_WORD, 16'hFFFF, 2'b11);
    apb_write(BCSCTL2_WORD, 16'hFFFF, 2'b11);
    // Unused words inside the block and a word outside it
    apb_read(16'h0050, rd);
    check(rd, 0, "unmapped word 0x0050");
    apb_read(16'h005A, rd);
    check(rd, 0, "unmapped word 0x005A");
    apb_read(16'h0156, rd);
    check(rd, 0, "address outside the block");
    apb_write(BCSCTL1_WORD, 16'h0000, 2'b11);
    apb_write(BCSCTL2_WORD, 16'h0000, 2'b11);
  endtask

  task automatic test_aclk_div();
    int n_aclk;
    int n_smclk;
    for (int code = 0; code < 4; code++) begin
      write_divax(code);
      wait_cycles(2);
      // 8 divided ACLK periods
      count_enables(8 * (1 << code) * LFXT_CYCLES, n_aclk, n_smclk);
      check(n_aclk, 8, $sformatf("aclk_en pulses with DIVAx=%0d", code));
    end
    write_divax(0);
  endtask

  task automatic test_smclk_div();
    int n_aclk;
    int n_smclk;
    // SMCLK from mclk ticks every cycle
    for (int code = 0; code < 4; code++) begin
      write_bcsctl2(0, code);
      wait_cycles(2);
      count_enables(64 * (1 << code), n_aclk, n_smclk);
      check(n_smclk, 64, $sformatf("smclk_en pulses with DIVSx=%0d", code));
    end
    write_bcsctl2(0, 0);
    @(posedge mclk);
    scg1 <= 1'b1;
    wait_cycles(2);
    count_enables(64, n_aclk, n_smclk);
    check(n_smclk, 0, "smclk_en with scg1 set");
    @(posedge mclk);
    scg1 <= 1'b0;
  endtask

  task automatic test_crystal();
    int n_aclk;
    int n_smclk;
    // SMCLK from the crystal follows the ACLK rule
    for (int code = 0; code < 4; code++) begin
      write_bcsctl2(1, code);
      wait_cycles(2);
      count_enables(8 * (1 << code) * LFXT_CYCLES, n_aclk, n_smclk);
      check(n_smclk, 8, $sformatf("smclk_en on crystal with DIVSx=%0d", code));
    end
    write_bcsctl2(0, 0);
    @(posedge mclk);
    oscoff <= 1'b1;
    wait_cycles(2);
    count_enables(8 * LFXT_CYCLES, n_aclk, n_smclk);
    check(n_aclk, 0, "aclk_en with oscoff set and SELS low");
    // Crystal kept alive while SMCLK uses it
    write_bcsctl2(1, 0);
    wait_cycles(2);
    count_enables(8 * LFXT_CYCLES, n_aclk, n_smclk);
    check(n_aclk, 8, "aclk_en with oscoff set and SELS high");
    @(posedge mclk);
    oscoff <= 1'b0;
    write_bcsctl2(0, 0);
  endtask

  task automatic test_cpu_en();
    int n_aclk;
    int n_smclk;
    int waited;
    @(posedge mclk);
    cpu_en <= 1'b0;
    wait_cycles(10);
    count_enables(8 * LFXT_CYCLES, n_aclk, n_smclk);
    check(n_aclk, 0, "aclk_en with cpu_en low");
    check(n_smclk, 0, "smclk_en with cpu_en low");
    @(posedge mclk);
    cpu_en <= 1'b1;
    waited = 0;
    @(negedge mclk);
    while (!cpu_en_s && waited < 4) begin
      @(negedge mclk);
      waited++;
    end
    check(int'(cpu_en_s), 1, "cpu_en_s after cpu_en returns high");
  endtask

  ////////////////////////////////////////
  // Run
  ////////////////////////////////////////

  initial begin
    logic [31:0] seed_draw;
    int          assert_fails;
    mclk      = 1'b0;
    puc_rst   = 1'b1;
    paddr     = 16'h0000;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = 16'h0000;
    pstrb     = 2'b00;
    lfxt_clk  = 1'b0;
    lfxt_cnt  = 3'd0;
    oscoff    = 1'b0;
    scg1      = 1'b0;
    cpu_en    = 1'b1;
    errors    = 0;
    seed_draw = $urandom(32'h81d8);
    test_reset();
    test_registers();
    test_aclk_div();
    test_smclk_div();
    test_crystal();
    test_cpu_en();
    assert_fails = uut.u_aclk_div.u_div_chk.fail_cnt + uut.u_smclk_div.u_div_chk.fail_cnt;
    $display("Summary: %0d check errors, %0d assertion failures", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Hang guard at twice the expected run time
  initial begin
    #(2 * RUN_CYCLES * CLK_PERIOD);
    $display("Watchdog timeout at %0d ns, the tests did not finish", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- tb/bcm_divider_assert.sv
`timescale 1ns/1ps

module bcm_divider_assert (
  input logic                  mclk,
  input logic                  puc_rst,
  input logic                  tick,
  input bcm_clk_pkg::div_sel_t div_sel,
  input logic                  cpu_en_s,
  input logic                  clk_en
);

  import bcm_clk_pkg::*;

  // Failure tally, summed by the testbench at the end
  int fail_cnt = 0;

  ////////////////////////////////////////
  // Divider output rules
  ////////////////////////////////////////

  // An enable pulse always follows a source tick
  a_tick_before_en : assert property (
    @(posedge mclk) disable iff (puc_rst)
    $rose(clk_en) |-> $past(tick)
  ) else begin
    fail_cnt++;
    $error("clk_en rose without a tick in the previous cycle");
  end

  // CPU disabled means no enable one cycle later
  a_cpu_en_gate : assert property (
    @(posedge mclk) disable iff (puc_rst)
    !$past(cpu_en_s) |-> !clk_en
  ) else begin
    fail_cnt++;
    $error("clk_en high after cpu_en_s was low");
  end

  // Any real division leaves a gap after each pulse
  // code must be stable, a switch from DIV_1 may still pulse twice
  a_no_double_pulse : assert property (
    @(posedge mclk) disable iff (puc_rst)
    clk_en && (div_sel != DIV_1) && $stable(div_sel) |=> !clk_en
  ) else begin
    fail_cnt++;
    $error("clk_en high on two consecutive cycles while dividing");
  end

endmodule

// Each divider instance gets its own checker
bind bcm_clk_divider bcm_divider_assert u_div_chk (
  .mclk     (mclk),
  .puc_rst  (puc_rst),
  .tick     (tick),
  .div_sel  (div_sel),
  .cpu_en_s (cpu_en_s),
  .clk_en   (clk_en)
);

//--- hdl/bcm_top.sv
`timescale 1ns/1ps

module bcm_top (
  input  logic        mclk,
  input  logic        puc_rst,
  // APB slave
  input  logic [15:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [15:0] pwdata,
  input  logic [1:0]  pstrb,
  output logic [15:0] prdata,
  // Oscillator and low power controls
  input  logic        lfxt_clk,
  input  logic        oscoff,
  input  logic        scg1,
  // CPU enable, asynchronous
  input  logic        cpu_en,
  output logic        cpu_en_s,
  // Clock enables for the peripherals
  output logic        aclk_en,
  output logic        smclk_en
);

  import bcm_clk_pkg::*;

  // Register fields
  div_sel_t divax;
  div_sel_t divsx;
  logic     sels;

  // Undivided source ticks
  logic aclk_tick;
  logic smclk_tick;

  ////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////

  bcm_apb_regs u_regs (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .divax   (divax),
    .divsx   (divsx),
    .sels    (sels)
  );

  ////////////////////////////////////////
  // Sources and enables
  ////////////////////////////////////////

  bcm_clk_sources u_sources (
    .mclk       (mclk),
    .puc_rst    (puc_rst),
    .lfxt_clk   (lfxt_clk),
    .oscoff     (oscoff),
    .scg1       (scg1),
    .sels       (sels),
    .aclk_tick  (aclk_tick),
    .smclk_tick (smclk_tick)
  );

  // cpu_en gates both dividers
  bcm_sync_cell u_cpu_en_sync (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .d       (cpu_en),
    .q       (cpu_en_s)
  );

  // ACLK from the crystal, divided by DIVAx
  bcm_clk_divider u_aclk_div (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .tick     (aclk_tick),
    .div_sel  (divax),
    .cpu_en_s (cpu_en_s),
    .clk_en   (aclk_en)
  );

  // SMCLK from the selected source, divided by DIVSx
  bcm_clk_divider u_smclk_div (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .tick     (smclk_tick),
    .div_sel  (divsx),
    .cpu_en_s (cpu_en_s),
    .clk_en   (smclk_en)
  );

endmodule

//--- hdl/bcm_clk_divider.sv
`timescale 1ns/1ps

module bcm_clk_divider (
  input  logic                  mclk,
  input  logic                  puc_rst,
  // Source tick, one mclk cycle wide
  input  logic                  tick,
  // Divide code from the control register
  input  bcm_clk_pkg::div_sel_t div_sel,
  // Synchronized CPU enable
  input  logic                  cpu_en_s,
  // Divided clock enable
  output logic                  clk_en
);

  import bcm_clk_pkg::*;

  ////////////////////////////////////////
  // Tick counter
  ////////////////////////////////////////

  logic [BCM_DIV_WD-1:0] div_cnt;
  logic                  div_hit;

  // Counter is parked at DIV_1
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      div_cnt <= '0;
    end else if (tick && (div_sel != DIV_1)) begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Low counter bits all ones marks the qualifying tick
  always_comb begin
    case (div_sel)
      DIV_2:   div_hit = div_cnt[0];
      DIV_4:   div_hit = &div_cnt[1:0];
      DIV_8:   div_hit = &div_cnt[2:0];
      default: div_hit = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // Enable output
  ////////////////////////////////////////

  // Registered, one cycle after the tick
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      clk_en <= 1'b0;
    end else begin
      clk_en <= tick & div_hit & cpu_en_s;
    end
  end

endmodule

//--- hdl/bcm_clk_sources.sv
`timescale 1ns/1ps

module bcm_clk_sources (
  input  logic mclk,
  input  logic puc_rst,
  // Low frequency crystal, asynchronous to mclk
  input  logic lfxt_clk,
  // Crystal off request from the status register
  input  logic oscoff,
  // SMCLK off request from the status register
  input  logic scg1,
  // SMCLK source, high selects the crystal
  input  logic sels,
  output logic aclk_tick,
  output logic smclk_tick
);

  ////////////////////////////////////////
  // Crystal resync and edge detect
  ////////////////////////////////////////

  logic lfxt_clk_s;
  logic lfxt_clk_dly;
  logic lfxt_rise;

  // Bring the crystal into the mclk domain
  bcm_sync_cell u_lfxt_sync (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .d       (lfxt_clk),
    .q       (lfxt_clk_s)
  );

  // Previous sample for edge detection
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      lfxt_clk_dly <= 1'b0;
    end else begin
      lfxt_clk_dly <= lfxt_clk_s;
    end
  end

  // One mclk cycle per crystal period
  assign lfxt_rise = lfxt_clk_s & ~lfxt_clk_dly;

  ////////////////////////////////////////
  // Source ticks
  ////////////////////////////////////////

  // oscoff only stops the crystal when SMCLK does not use it
  assign aclk_tick = lfxt_rise & ~(oscoff & ~sels);

  // SMCLK runs from mclk or from the crystal tick
  // scg1 stops it in both cases
  assign smclk_tick = ~scg1 & (sels ? aclk_tick : 1'b1);

endmodule

//--- hdl/bcm_apb_regs.sv
`timescale 1ns/1ps

module bcm_apb_regs (
  input  logic                  mclk,
  input  logic                  puc_rst,
  // APB slave, zero wait states
  input  logic [15:0]           paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [15:0]           pwdata,
  input  logic [1:0]            pstrb,
  output logic [15:0]           prdata,
  // Register fields
  output bcm_clk_pkg::div_sel_t divax,
  output bcm_clk_pkg::div_sel_t divsx,
  output logic                  sels
);

  import bcm_reg_pkg::*;
  import bcm_clk_pkg::*;

  ////////////////////////////////////////
  // Address decoder
  ////////////////////////////////////////

  // Block hit on the upper address bits
  logic                  blk_sel;
  // Word index inside the block
  logic [BCM_DEC_WD-2:0] word_addr;
  logic                  apb_wr;
  logic                  apb_rd;

  assign blk_sel   = psel & (paddr[15:BCM_DEC_WD] == BCM_BASE_ADDR[15:BCM_DEC_WD]);
  assign word_addr = paddr[BCM_DEC_WD-1:1];

  // Write commits at the end of the access phase
  assign apb_wr = blk_sel & penable & pwrite;
  assign apb_rd = blk_sel & penable & ~pwrite;

  // Per register word match
  logic bcsctl1_hit;
  logic bcsctl2_hit;

  assign bcsctl1_hit = (word_addr == BCSCTL1_OFS[BCM_DEC_WD-1:1]);
  assign bcsctl2_hit = (word_addr == BCSCTL2_OFS[BCM_DEC_WD-1:1]);

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  logic [7:0] bcsctl1;
  logic [7:0] bcsctl2;
  logic       bcsctl1_wr;
  logic       bcsctl2_wr;

  // Offset bit 0 picks the byte lane and its strobe
  assign bcsctl1_wr = apb_wr & bcsctl1_hit & pstrb[BCSCTL1_OFS[0]];
  assign bcsctl2_wr = apb_wr & bcsctl2_hit & pstrb[BCSCTL2_OFS[0]];

  // BCSCTL1, unused bits forced to zero
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      bcsctl1 <= 8'h00;
    end else if (bcsctl1_wr) begin
      bcsctl1 <= pwdata[8*BCSCTL1_OFS[0] +: 8] & BCSCTL1_MASK;
    end
  end

  // BCSCTL2, unused bits forced to zero
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      bcsctl2 <= 8'h00;
    end else if (bcsctl2_wr) begin
      bcsctl2 <= pwdata[8*BCSCTL2_OFS[0] +: 8] & BCSCTL2_MASK;
    end
  end

  // Field outputs to the clock logic
  assign divax = div_sel_t'(bcsctl1[DIVAX_LSB +: 2]);
  assign divsx = div_sel_t'(bcsctl2[DIVSX_LSB +: 2]);
  assign sels  = bcsctl2[SELS_BIT];

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  logic [7:0]  bcsctl1_byte;
  logic [7:0]  bcsctl2_byte;
  logic [15:0] bcsctl1_rd;
  logic [15:0] bcsctl2_rd;

  // Masked byte, zero unless selected
  assign bcsctl1_byte = bcsctl1 & BCSCTL1_MASK & {8{apb_rd & bcsctl1_hit}};
  assign bcsctl2_byte = bcsctl2 & BCSCTL2_MASK & {8{apb_rd & bcsctl2_hit}};

  // Place each byte in its own lane
  assign bcsctl1_rd = BCSCTL1_OFS[0] ? {bcsctl1_byte, 8'h00} : {8'h00, bcsctl1_byte};
  assign bcsctl2_rd = BCSCTL2_OFS[0] ? {bcsctl2_byte, 8'h00} : {8'h00, bcsctl2_byte};

  assign prdata = bcsctl1_rd | bcsctl2_rd;

endmodule

//--- hdl/bcm_sync_cell.sv
`timescale 1ns/1ps

module bcm_sync_cell (
  input  logic mclk,
  input  logic puc_rst,
  // Asynchronous input
  input  logic d,
  // Resynchronized to mclk
  output logic q
);

  import bcm_clk_pkg::*;

  // Shift chain, first stage may go metastable
  logic [BCM_SYNC_STAGES-1:0] sync_q;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[BCM_SYNC_STAGES-2:0], d};
    end
  end

  // Last stage is safe to use
  assign q = sync_q[BCM_SYNC_STAGES-1];

endmodule

//--- hdl/bcm_clk_pkg.sv
package bcm_clk_pkg;

  ////////////////////////////////////////
  // Clock divider
  ////////////////////////////////////////

  // Divider counter width, enough for divide by 8
  localparam int BCM_DIV_WD = 3;

  // Divide code as stored in DIVAx and DIVSx
  typedef enum logic [1:0] {
    DIV_1 = 2'b00,
    DIV_2 = 2'b01,
    DIV_4 = 2'b10,
    DIV_8 = 2'b11
  } div_sel_t;

  ////////////////////////////////////////
  // Resynchronization
  ////////////////////////////////////////

  // Flops in each synchronizer chain
  localparam int BCM_SYNC_STAGES = 2;

endpackage

//--- hdl/bcm_reg_pkg.sv
package bcm_reg_pkg;

  ////////////////////////////////////////
  // Register block placement
  ////////////////////////////////////////

  // Byte address of the basic clock module registers
  localparam logic [15:0] BCM_BASE_ADDR = 16'h0050;

  // Low address bits decoded inside the block
  localparam int BCM_DEC_WD = 4;

  ////////////////////////////////////////
  // Register byte offsets
  ////////////////////////////////////////

  // BCSCTL1 sits in the high byte of word 0x0056
  localparam logic [3:0] BCSCTL1_OFS = 4'h7;
  // BCSCTL2 sits in the low byte of word 0x0058
  localparam logic [3:0] BCSCTL2_OFS = 4'h8;

  // Implemented bits
  // DIVAx only
  localparam logic [7:0] BCSCTL1_MASK = 8'h30;
  // SELS and DIVSx, no MCLK divider or SELMx
  localparam logic [7:0] BCSCTL2_MASK = 8'h0E;

  ////////////////////////////////////////
  // Field positions
  ////////////////////////////////////////

  // ACLK divider code in BCSCTL1
  localparam int DIVAX_LSB = 4;
  // SMCLK source select in BCSCTL2
  localparam int SELS_BIT  = 3;
  // SMCLK divider code in BCSCTL2
  localparam int DIVSX_LSB = 1;

endpackage
